//--- Makefile
SIM      ?= verilator
FLAGS    ?= --binary --timing --assert --timescale 1ns/100ps
TOP      ?= tb_i2c_write
FILELIST ?= filelist.f
LOG      ?= sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run the testbench, check the log"
	@echo "  clean  remove build output and log"
	@echo "  help   list the targets"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "Everything OK" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- bus_phase_tracker.sv
module bus_phase_tracker
    import i2c_pkg::*;
#(
    parameter int SCL_HALF_CYCLES  = 250,
    parameter int SYNC_STAGES      = 2,
    parameter int DATA_HOLD_CYCLES = 12
) (
    input  logic       CLK,
    input  logic       reset,
    input  logic       scl_i,
    input  logic       sda_i,
    output logic       scl_high_o,
    output phase_evt_t evt_o
);

    localparam int IDLE_W = $clog2(SCL_HALF_CYCLES + 1);
    localparam int HOLD_W = $clog2(DATA_HOLD_CYCLES + 1);

    logic [SYNC_STAGES-1:0] scl_sync;
    logic [SYNC_STAGES-1:0] sda_sync;
    logic                   scl_s;
    logic                   sda_s;
    logic                   scl_prev;
    logic                   sda_prev;
    logic                   scl_fell;
    logic                   scl_rose;
    logic                   sda_fell;
    logic                   sda_rose;
    phase_e                 phase;
    logic [2:0]             bit_cnt;
    logic [IDLE_W-1:0]      idle_cnt;
    logic                   idle_hit;
    logic [HOLD_W-1:0]      hold_cnt;

    ////////////////////////////////////////
    // Synchronizers and edges
    ////////////////////////////////////////

    assign scl_s = scl_sync[SYNC_STAGES-1];
    assign sda_s = sda_sync[SYNC_STAGES-1];

    assign scl_fell = scl_prev & ~scl_s;
    assign scl_rose = ~scl_prev & scl_s;
    assign sda_fell = sda_prev & ~sda_s;
    assign sda_rose = ~sda_prev & sda_s;

    // Clock gen starts its high count from the same view of the line
    assign scl_high_o = scl_s;
    assign idle_hit   = (idle_cnt == IDLE_W'(SCL_HALF_CYCLES - 1));

    always_ff @(posedge CLK) begin
        if (reset) begin
            // Released lines read high
            scl_sync <= '1;
            sda_sync <= '1;
            scl_prev <= 1'b1;
            sda_prev <= 1'b1;
        end else begin
            scl_sync <= {scl_sync[SYNC_STAGES-2:0], scl_i};
            sda_sync <= {sda_sync[SYNC_STAGES-2:0], sda_i};
            scl_prev <= scl_s;
            sda_prev <= sda_s;
        end
    end

    ////////////////////////////////////////
    // Phase FSM and hold counter
    ////////////////////////////////////////

    always_ff @(posedge CLK) begin
        if (reset) begin
            phase    <= PH_IDLE;
            bit_cnt  <= '0;
            idle_cnt <= '0;
            hold_cnt <= '0;
            evt_o    <= '0;
        end else begin
            // Hold delay restarts on every SCL fall
            if (scl_fell) begin
                hold_cnt <= HOLD_W'(DATA_HOLD_CYCLES);
            end else if (hold_cnt != '0) begin
                hold_cnt <= hold_cnt - 1'b1;
            end

            evt_o.scl_fell  <= scl_fell;
            evt_o.scl_rose  <= scl_rose;
            evt_o.hold_done <= (hold_cnt == HOLD_W'(1));
            evt_o.sda       <= sda_s;
            evt_o.bus_idle  <= (phase == PH_IDLE) && idle_hit;

            case (phase)
                PH_IDLE: begin
                    // Both lines high for a half period
                    if (!(scl_s && sda_s)) begin
                        idle_cnt <= '0;
                    end else if (idle_hit) begin
                        idle_cnt <= '0;
                        phase    <= PH_READY;
                    end else begin
                        idle_cnt <= idle_cnt + 1'b1;
                    end
                end
                PH_START_HELD: begin
                    if (scl_fell) begin
                        phase <= PH_SCL_LOW;
                    end
                end
                PH_SCL_LOW: begin
                    if (scl_rose) begin
                        phase <= PH_SCL_HIGH;
                    end
                end
                PH_ACK_LOW: begin
                    if (scl_rose) begin
                        phase <= PH_ACK_HIGH;
                    end
                end
                default: begin
                    // READY, SCL_HIGH, ACK_HIGH watch for start, stop and the next fall
                    if (scl_s && sda_fell) begin
                        bit_cnt <= '0;
                        phase   <= PH_START_HELD;
                    end else if (scl_s && sda_rose && phase != PH_READY) begin
                        phase <= PH_IDLE;
                    end else if (scl_fell && phase == PH_SCL_HIGH) begin
                        // Eighth data bit done, ninth clock is the ACK
                        bit_cnt <= bit_cnt + 1'b1;
                        phase   <= (bit_cnt == 3'd7) ? PH_ACK_LOW : PH_SCL_LOW;
                    end else if (scl_fell && phase == PH_ACK_HIGH) begin
                        phase <= PH_SCL_LOW;
                    end
                end
            endcase
        end
    end

endmodule

//--- filelist.f
i2c_pkg.sv
scl_clock_gen.sv
bus_phase_tracker.sv
write_sequencer.sv
i2c_write_top.sv
i2c_slave_model.sv
tb_i2c_write.sv

//--- i2c_pkg.sv
package i2c_pkg;

    ////////////////////////////////////////
    // State encodings
    ////////////////////////////////////////

    // Sequencer walk over the byte table
    typedef enum logic [2:0] {
        SEQ_IDLE,
        SEQ_START,
        SEQ_SEND_BIT,
        SEQ_ACK_CHECK,
        SEQ_RESTART,
        SEQ_STOP,
        SEQ_DONE
    } seq_state_e;

    // Bus phase as seen through the synchronizers
    typedef enum logic [2:0] {
        PH_IDLE,
        PH_READY,
        PH_START_HELD,
        PH_SCL_LOW,
        PH_SCL_HIGH,
        PH_ACK_LOW,
        PH_ACK_HIGH
    } phase_e;

    ////////////////////////////////////////
    // Bundles
    ////////////////////////////////////////

    // A set bit pulls that line low, a clear bit releases it
    typedef struct packed {
        logic scl_low;
        logic sda_low;
    } i2c_pad_t;

    // Single cycle event pulses, plus the sampled SDA level
    typedef struct packed {
        logic scl_fell;
        logic scl_rose;
        logic hold_done;
        logic sda;
        logic bus_idle;
    } phase_evt_t;

    ////////////////////////////////////////
    // Configuration sequence
    ////////////////////////////////////////

    localparam int BYTE_COUNT     = 5;
    // Second transaction starts here
    localparam int TXN_FIRST_BYTE = 2;

    typedef logic [2:0] byte_idx_t;

    // Switch addr + W, channel select, logic device addr + W, control reg, LED on
    localparam logic [7:0] byte_table [BYTE_COUNT] = '{8'hE2, 8'h80, 8'h7C, 8'h02, 8'h01};

endpackage

//--- i2c_slave_model.sv
module i2c_slave_model (
    input  logic       CLK,
    input  logic       reset,
    input  logic       scl_i,
    input  logic       sda_i,
    input  logic [7:0] nack_byte_i,
    input  logic [7:0] nack_count_i,
    output logic       sda_low_o,
    output logic       start_o,
    output logic       stop_o,
    output logic       byte_valid_o,
    output logic [7:0] byte_o
);
    timeunit 1ns;
    timeprecision 100ps;

    logic       scl_q;
    logic       sda_q;
    logic [3:0] bit_cnt;
    logic [7:0] shift;
    logic       acking;
    logic [7:0] nack_given;

    // Bus sampled on the falling clock edge, away from DUT updates
    always @(negedge CLK) begin
        start_o      <= 1'b0;
        stop_o       <= 1'b0;
        byte_valid_o <= 1'b0;
        scl_q        <= scl_i;
        sda_q        <= sda_i;
        if (reset) begin
            scl_q      <= 1'b1;
            sda_q      <= 1'b1;
            bit_cnt    <= '0;
            shift      <= '0;
            acking     <= 1'b0;
            nack_given <= '0;
            sda_low_o  <= 1'b0;
            byte_o     <= '0;
        end else if (scl_q && scl_i && sda_q && !sda_i) begin
            // Start or repeated start
            start_o   <= 1'b1;
            bit_cnt   <= '0;
            acking    <= 1'b0;
            sda_low_o <= 1'b0;
        end else if (scl_q && scl_i && !sda_q && sda_i) begin
            // Stop
            stop_o    <= 1'b1;
            bit_cnt   <= '0;
            acking    <= 1'b0;
            sda_low_o <= 1'b0;
        end else if (!scl_q && scl_i && bit_cnt < 4'd8) begin
            // Data bit, MSB first
            shift   <= {shift[6:0], sda_i};
            bit_cnt <= bit_cnt + 4'd1;
            if (bit_cnt == 4'd7) begin
                byte_valid_o <= 1'b1;
                byte_o       <= {shift[6:0], sda_i};
            end
        end else if (scl_q && !scl_i) begin
            if (acking) begin
                // End of the ACK clock
                sda_low_o <= 1'b0;
                acking    <= 1'b0;
                bit_cnt   <= '0;
            end else if (bit_cnt == 4'd8) begin
                acking <= 1'b1;
                // NACK leaves SDA released
                if (shift == nack_byte_i && nack_given < nack_count_i) begin
                    nack_given <= nack_given + 8'd1;
                end else begin
                    sda_low_o <= 1'b1;
                end
            end
        end
    end

endmodule

//--- i2c_write_top.sv
module i2c_write_top
    import i2c_pkg::*;
#(
    parameter int SCL_HALF_CYCLES  = 250,
    parameter int SYNC_STAGES      = 2,
    parameter int DATA_HOLD_CYCLES = 12,
    parameter int MAX_RETRIES      = 3
) (
    input  logic     CLK,
    input  logic     reset,
    input  logic     scl_i,
    input  logic     sda_i,
    output i2c_pad_t pad_o,
    output logic     done_o,
    output logic     fail_o
);

    // Phase events from the tracker
    phase_evt_t evt;
    logic       scl_high;

    // Clock generator handshake
    logic run;
    logic start_req;
    logic stop_req;
    logic start_done;
    logic stop_done;

    // Drive bits toward the pads
    logic scl_low;
    logic sda_low;

    scl_clock_gen #(
        .SCL_HALF_CYCLES (SCL_HALF_CYCLES)
    ) scl_clock_gen_i (
        .CLK          (CLK),
        .reset        (reset),
        .run_i        (run),
        .start_req_i  (start_req),
        .stop_req_i   (stop_req),
        .scl_high_i   (scl_high),
        .scl_low_o    (scl_low),
        .start_done_o (start_done),
        .stop_done_o  (stop_done)
    );

    bus_phase_tracker #(
        .SCL_HALF_CYCLES  (SCL_HALF_CYCLES),
        .SYNC_STAGES      (SYNC_STAGES),
        .DATA_HOLD_CYCLES (DATA_HOLD_CYCLES)
    ) bus_phase_tracker_i (
        .CLK        (CLK),
        .reset      (reset),
        .scl_i      (scl_i),
        .sda_i      (sda_i),
        .scl_high_o (scl_high),
        .evt_o      (evt)
    );

    write_sequencer #(
        .MAX_RETRIES (MAX_RETRIES)
    ) write_sequencer_i (
        .CLK          (CLK),
        .reset        (reset),
        .evt_i        (evt),
        .start_done_i (start_done),
        .stop_done_i  (stop_done),
        .run_o        (run),
        .start_req_o  (start_req),
        .stop_req_o   (stop_req),
        .sda_low_o    (sda_low),
        .done_o       (done_o),
        .fail_o       (fail_o)
    );

    // Open-drain pulls toward the pins
    assign pad_o.scl_low = scl_low;
    assign pad_o.sda_low = sda_low;

endmodule

//--- scl_clock_gen.sv
module scl_clock_gen #(
    parameter int SCL_HALF_CYCLES = 250
) (
    input  logic CLK,
    input  logic reset,
    input  logic run_i,
    input  logic start_req_i,
    input  logic stop_req_i,
    input  logic scl_high_i,
    output logic scl_low_o,
    output logic start_done_o,
    output logic stop_done_o
);

    localparam int CNT_W = $clog2(SCL_HALF_CYCLES + 1);

    logic [CNT_W-1:0] half_cnt;
    logic             half_end;
    logic             req_q;
    logic             req_new;

    assign half_end = (half_cnt == CNT_W'(SCL_HALF_CYCLES - 1));
    // First cycle of a start or stop request
    assign req_new  = (start_req_i | stop_req_i) & ~req_q;

    always_ff @(posedge CLK) begin
        if (reset) begin
            scl_low_o    <= 1'b0;
            half_cnt     <= '0;
            req_q        <= 1'b0;
            start_done_o <= 1'b0;
            stop_done_o  <= 1'b0;
        end else begin
            req_q        <= start_req_i | stop_req_i;
            start_done_o <= 1'b0;
            stop_done_o  <= 1'b0;
            if (scl_low_o) begin
                // Low half, release at the end
                if (half_end) begin
                    scl_low_o <= 1'b0;
                    half_cnt  <= '0;
                end else begin
                    half_cnt <= half_cnt + 1'b1;
                end
            end else if (!scl_high_i || req_new) begin
                // Line still low (target stretching) or SDA just moved
                half_cnt <= '0;
            end else if (half_end) begin
                half_cnt <= '0;
                // Stop keeps SCL released for good
                if (stop_req_i) begin
                    stop_done_o <= 1'b1;
                end else if (start_req_i) begin
                    start_done_o <= 1'b1;
                    scl_low_o    <= 1'b1;
                end else if (run_i) begin
                    scl_low_o <= 1'b1;
                end
            end else begin
                half_cnt <= half_cnt + 1'b1;
            end
        end
    end

endmodule

//--- tb_i2c_write.sv
module tb_i2c_write
    import i2c_pkg::*;
;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int SCL_HALF   = 8;
    localparam int SYNC_DEPTH = 2;
    localparam int HOLD       = 3;
    localparam int RETRIES    = 3;
    // Worst case per run with margin
    localparam int RUN_LIMIT  = 12 * BYTE_COUNT * 9 * 2 * SCL_HALF * (RETRIES + 1);
    localparam int RUN_COUNT  = 4;
    localparam int TOKEN_S    = 256;
    localparam int TOKEN_P    = 257;

    // Switch address + W, channel select, device address + W, control reg, indicator on
    localparam logic [7:0] CFG_BYTES [5] = '{8'hE2, 8'h80, 8'h7C, 8'h02, 8'h01};

    logic       CLK;
    logic       reset;
    i2c_pad_t   dut_pad;
    logic       done_o;
    logic       fail_o;
    logic       scl_line;
    logic       sda_line;
    logic       slave_sda_low;
    logic       stretch_low;
    logic       stretch_en;
    logic [4:0] stretch_cnt;
    logic       scl_seen;
    logic [31:0] rnd;
    logic [7:0] nack_byte;
    logic [7:0] nack_count;
    logic       ev_start;
    logic       ev_stop;
    logic       ev_byte;
    logic [7:0] rx_byte;
    logic       bus_scl_q;
    logic       bus_sda_q;
    int         rise_cnt;
    int         seed;
    int         cycles;
    int         assert_errs;
    int         log_errs;
    int         log_q[$];
    int         exp_q[$];

    ////////////////////////////////////////
    // Clock, bus and DUT
    ////////////////////////////////////////

    initial begin
        CLK = 1'b0;
        forever #2 CLK = ~CLK;
    end

    // Wired-AND of all open-drain pulls
    assign scl_line = ~(dut_pad.scl_low | stretch_low);
    assign sda_line = ~(dut_pad.sda_low | slave_sda_low);

    i2c_write_top #(
        .SCL_HALF_CYCLES  (SCL_HALF),
        .SYNC_STAGES      (SYNC_DEPTH),
        .DATA_HOLD_CYCLES (HOLD),
        .MAX_RETRIES      (RETRIES)
    ) i2c_write_top_i (
        .CLK    (CLK),
        .reset  (reset),
        .scl_i  (scl_line),
        .sda_i  (sda_line),
        .pad_o  (dut_pad),
        .done_o (done_o),
        .fail_o (fail_o)
    );

    i2c_slave_model slave_i (
        .CLK          (CLK),
        .reset        (reset),
        .scl_i        (scl_line),
        .sda_i        (sda_line),
        .nack_byte_i  (nack_byte),
        .nack_count_i (nack_count),
        .sda_low_o    (slave_sda_low),
        .start_o      (ev_start),
        .stop_o       (ev_stop),
        .byte_valid_o (ev_byte),
        .byte_o       (rx_byte)
    );

    // Target holds SCL low for a random time after each fall
    always @(negedge CLK) begin
        scl_seen <= scl_line;
        if (reset) begin
            stretch_low <= 1'b0;
            stretch_cnt <= '0;
            scl_seen    <= 1'b1;
        end else if (stretch_en && scl_seen && !scl_line) begin
            rnd = $random(seed);
            stretch_cnt <= 5'd8 + {1'b0, rnd[3:0]};
            stretch_low <= 1'b1;
        end else if (stretch_cnt > 5'd1) begin
            stretch_cnt <= stretch_cnt - 5'd1;
        end else begin
            stretch_cnt <= '0;
            stretch_low <= 1'b0;
        end
    end

    // Bus events as seen by the target, in order
    always @(posedge CLK) begin
        if (ev_start) begin
            log_q.push_back(TOKEN_S);
        end
        if (ev_stop) begin
            log_q.push_back(TOKEN_P);
        end
        if (ev_byte) begin
            log_q.push_back(int'(rx_byte));
        end
    end

    // SCL rises since the last start or stop, one before the first start
    always @(posedge CLK) begin
        bus_scl_q <= scl_line;
        bus_sda_q <= sda_line;
        if (reset) begin
            rise_cnt <= 1;
        end else if (bus_scl_q && scl_line && bus_sda_q != sda_line) begin
            rise_cnt <= 0;
        end else if (!bus_scl_q && scl_line) begin
            rise_cnt <= rise_cnt + 1;
        end
    end

    ////////////////////////////////////////
    // Assertions and watchdog
    ////////////////////////////////////////

    a_reset_state: assert property (@(posedge CLK)
        $past(reset) |-> (dut_pad == 2'b00 && !done_o && !fail_o))
        else begin
            assert_errs++;
            $display("[FAIL] %0t outputs not cleared by reset", $time);
        end

    // Start or stop only after whole bytes with their ACK clock plus one more clock
    a_sda_stable: assert property (@(posedge CLK) disable iff (reset)
        (bus_scl_q && scl_line && bus_sda_q != sda_line) |-> (rise_cnt % 9 == 1))
        else begin
            assert_errs++;
            $display("[FAIL] %0t SDA changed while SCL high inside a byte", $time);
        end

    a_done_sticky: assert property (@(posedge CLK) disable iff (reset)
        $past(done_o) |-> done_o)
        else begin
            assert_errs++;
            $display("[FAIL] %0t done_o dropped before reset", $time);
        end

    a_fail_sticky: assert property (@(posedge CLK) disable iff (reset)
        $past(fail_o) |-> fail_o)
        else begin
            assert_errs++;
            $display("[FAIL] %0t fail_o dropped before reset", $time);
        end

    a_one_result: assert property (@(posedge CLK) disable iff (reset)
        !(done_o && fail_o))
        else begin
            assert_errs++;
            $display("[FAIL] %0t done_o and fail_o both high", $time);
        end

    always @(posedge CLK) begin
        cycles <= cycles + 1;
        if (cycles > RUN_COUNT * (RUN_LIMIT + 64)) begin
            $display("Timeout: the runs did not finish within %0d cycles", cycles);
            $display("Something failed");
            $finish;
        end
    end

    ////////////////////////////////////////
    // Run control
    ////////////////////////////////////////

    task automatic apply_reset(input logic [7:0] nbyte, input logic [7:0] ncount,
                               input logic stretch);
        @(negedge CLK);
        reset      = 1'b1;
        nack_byte  = nbyte;
        nack_count = ncount;
        stretch_en = stretch;
        repeat (16) @(negedge CLK);
        log_q.delete();
        exp_q.delete();
        reset = 1'b0;
    endtask

    task automatic wait_result();
        while (!(done_o || fail_o)) begin
            @(negedge CLK);
        end
        // Let the last bus events land in the log
        repeat (4) @(negedge CLK);
    endtask

    task automatic expect_txn(input int first, input int last);
        exp_q.push_back(TOKEN_S);
        for (int i = first; i <= last; i++) begin
            exp_q.push_back(int'(CFG_BYTES[i]));
        end
    endtask

    task automatic compare_log(input string name, input logic want_done);
        int n;
        n = (log_q.size() < exp_q.size()) ? log_q.size() : exp_q.size();
        assert (log_q.size() == exp_q.size()) else begin
            log_errs++;
            $display("[FAIL] %0t %s: %0d bus events, expected %0d",
                     $time, name, log_q.size(), exp_q.size());
        end
        for (int i = 0; i < n; i++) begin
            assert (log_q[i] == exp_q[i]) else begin
                log_errs++;
                $display("[FAIL] %0t %s: event %0d is %0h, expected %0h",
                         $time, name, i, log_q[i], exp_q[i]);
            end
        end
        assert (done_o == want_done && fail_o == !want_done) else begin
            log_errs++;
            $display("[FAIL] %0t %s: done_o %b fail_o %b", $time, name, done_o, fail_o);
        end
    endtask

    initial begin
        seed        = 32'h7e0f;
        cycles      = 0;
        assert_errs = 0;
        log_errs    = 0;
        reset       = 1'b1;
        nack_byte   = 8'h00;
        nack_count  = 8'd0;
        stretch_en  = 1'b0;

        // Every byte ACKed
        apply_reset(8'h00, 8'd0, 1'b0);
        wait_result();
        expect_txn(0, TXN_FIRST_BYTE - 1);
        expect_txn(TXN_FIRST_BYTE, BYTE_COUNT - 1);
        exp_q.push_back(TOKEN_P);
        compare_log("all ack", 1'b1);

        // One NACK on the control register index
        apply_reset(8'h02, 8'd1, 1'b0);
        wait_result();
        expect_txn(0, TXN_FIRST_BYTE - 1);
        expect_txn(TXN_FIRST_BYTE, 3);
        expect_txn(TXN_FIRST_BYTE, BYTE_COUNT - 1);
        exp_q.push_back(TOKEN_P);
        compare_log("single nack", 1'b1);

        // Switch address never answers
        apply_reset(8'hE2, 8'd255, 1'b0);
        wait_result();
        for (int i = 0; i < RETRIES; i++) begin
            expect_txn(0, 0);
        end
        exp_q.push_back(TOKEN_P);
        compare_log("retries", 1'b0);

        // Random clock stretching
        apply_reset(8'h00, 8'd0, 1'b1);
        wait_result();
        expect_txn(0, TXN_FIRST_BYTE - 1);
        expect_txn(TXN_FIRST_BYTE, BYTE_COUNT - 1);
        exp_q.push_back(TOKEN_P);
        compare_log("stretch", 1'b1);

        $display("Errors: %0d assertion, %0d bus log", assert_errs, log_errs);
        if (assert_errs == 0 && log_errs == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

//--- write_sequencer.sv
module write_sequencer
    import i2c_pkg::*;
#(
    parameter int MAX_RETRIES = 3
) (
    input  logic       CLK,
    input  logic       reset,
    input  phase_evt_t evt_i,
    input  logic       start_done_i,
    input  logic       stop_done_i,
    output logic       run_o,
    output logic       start_req_o,
    output logic       stop_req_o,
    output logic       sda_low_o,
    output logic       done_o,
    output logic       fail_o
);

    localparam int TRY_W = $clog2(MAX_RETRIES + 1);

    seq_state_e       state;
    byte_idx_t        byte_idx;
    logic [2:0]       bit_cnt;
    logic [TRY_W-1:0] tries;
    logic             give_up;
    logic             cur_bit;
    logic             last_byte;
    logic             txn_end;
    byte_idx_t        txn_start;

    ////////////////////////////////////////
    // Table lookup
    ////////////////////////////////////////

    // MSB first
    assign cur_bit   = byte_table[byte_idx][bit_cnt];
    assign last_byte = (byte_idx == byte_idx_t'(BYTE_COUNT - 1));
    // Last byte of the first transaction
    assign txn_end   = (byte_idx == byte_idx_t'(TXN_FIRST_BYTE - 1));
    // Address byte of the transaction in flight
    assign txn_start = (byte_idx < byte_idx_t'(TXN_FIRST_BYTE)) ?
                       '0 : byte_idx_t'(TXN_FIRST_BYTE);

    // SCL toggles whenever a byte, ACK, restart or stop is under way
    assign run_o       = (state == SEQ_SEND_BIT) || (state == SEQ_ACK_CHECK) ||
                         (state == SEQ_RESTART) || (state == SEQ_STOP);
    assign start_req_o = (state == SEQ_START);

    ////////////////////////////////////////
    // Sequencer FSM
    ////////////////////////////////////////

    always_ff @(posedge CLK) begin
        if (reset) begin
            state      <= SEQ_IDLE;
            byte_idx   <= '0;
            bit_cnt    <= 3'd7;
            tries      <= '0;
            give_up    <= 1'b0;
            stop_req_o <= 1'b0;
            sda_low_o  <= 1'b0;
            done_o     <= 1'b0;
            fail_o     <= 1'b0;
        end else begin
            case (state)
                SEQ_IDLE: begin
                    // SDA falls while SCL is high
                    if (evt_i.bus_idle) begin
                        sda_low_o <= 1'b1;
                        state     <= SEQ_START;
                    end
                end
                SEQ_START: begin
                    if (start_done_i) begin
                        bit_cnt <= 3'd7;
                        state   <= SEQ_SEND_BIT;
                    end
                end
                SEQ_SEND_BIT: begin
                    // New data only once the hold delay after the fall has run out
                    if (evt_i.hold_done) begin
                        sda_low_o <= ~cur_bit;
                    end
                    if (evt_i.scl_rose) begin
                        if (bit_cnt == 3'd0) begin
                            state <= SEQ_ACK_CHECK;
                        end else begin
                            bit_cnt <= bit_cnt - 1'b1;
                        end
                    end
                end
                SEQ_ACK_CHECK: begin
                    // Hand SDA to the target for the ninth bit
                    if (evt_i.hold_done) begin
                        sda_low_o <= 1'b0;
                    end
                    if (evt_i.scl_rose) begin
                        bit_cnt <= 3'd7;
                        if (!evt_i.sda) begin
                            if (last_byte) begin
                                state <= SEQ_STOP;
                            end else begin
                                byte_idx <= byte_idx + 1'b1;
                                if (txn_end) begin
                                    // Fresh attempt budget for the next target
                                    tries <= '0;
                                    state <= SEQ_RESTART;
                                end else begin
                                    state <= SEQ_SEND_BIT;
                                end
                            end
                        end else if (tries == TRY_W'(MAX_RETRIES - 1)) begin
                            give_up <= 1'b1;
                            state   <= SEQ_STOP;
                        end else begin
                            // NACK, resend from the address byte
                            tries    <= tries + 1'b1;
                            byte_idx <= txn_start;
                            state    <= SEQ_RESTART;
                        end
                    end
                end
                SEQ_RESTART: begin
                    // SDA already released, pull it low in the next SCL high
                    if (evt_i.scl_rose) begin
                        sda_low_o <= 1'b1;
                        state     <= SEQ_START;
                    end
                end
                SEQ_STOP: begin
                    // SDA low while SCL is low, then release it with SCL high
                    if (evt_i.hold_done) begin
                        sda_low_o  <= 1'b1;
                        stop_req_o <= 1'b1;
                    end
                    if (stop_done_i) begin
                        sda_low_o  <= 1'b0;
                        stop_req_o <= 1'b0;
                        state      <= SEQ_DONE;
                    end
                end
                SEQ_DONE: begin
                    done_o <= ~give_up;
                    fail_o <= give_up;
                end
                default: begin
                    state <= SEQ_IDLE;
                end
            endcase
        end
    end

endmodule
